// File: design/hwpf_config.svh
/*
 * Stride prefetcher configuration
 * Widths of addresses and counters, and the bit positions of the fields
 * inside the base, param and throttle configuration words.
 */
`ifndef HWPF_CONFIG_SVH
`define HWPF_CONFIG_SVH

`define HWPF_ADDR_W       64
`define HWPF_WORD_W       64   // config word width
`define HWPF_LINE_OFS     6    // 64-byte lines
`define HWPF_LINE_W       (`HWPF_ADDR_W - `HWPF_LINE_OFS)
`define HWPF_STRIDE_W     16
`define HWPF_NLINES_W     16
`define HWPF_NWAIT_W      16
`define HWPF_SNOOP_PORTS  2

// base word layout, line field starts at HWPF_LINE_OFS
`define HWPF_BASE_EN_BIT       0
`define HWPF_BASE_REARM_BIT    1
`define HWPF_PARAM_STRIDE_LSB  0
`define HWPF_PARAM_NLINES_LSB  16
`define HWPF_THROTTLE_NWAIT_LSB 0

`endif

// File: design/hwpf_pkg.sv
/*
 * Stride prefetcher package
 * Line address type and the issue FSM state encoding.
 */
`include "hwpf_config.svh"

package hwpf_pkg;

  // cache line address, offset bits dropped
  typedef logic [`HWPF_LINE_W-1:0] line_addr_t;

  typedef enum logic [2:0] {
    IDLE,      // waiting for a matching snoop
    REQ,       // request up, waiting for ack
    ACK_LOW,   // request down, waiting for ack to drop
    THROTTLE,  // spacing between two requests
    DONE       // end of run
  } issue_state_e;

endpackage : hwpf_pkg

// File: design/hwpf_cfg_if.sv
/*
 * Stride prefetcher configuration bundle
 * Decoded config fields from the register block to the engine, and the
 * end-of-run pulse back from the FSM.
 */
`include "hwpf_config.svh"

interface hwpf_cfg_if;

  logic                        enable;
  logic                        rearm;
  logic [`HWPF_LINE_W-1:0]     base_line;
  logic [`HWPF_STRIDE_W-1:0]   stride;     // in lines
  logic [`HWPF_NLINES_W-1:0]   nlines;
  logic [`HWPF_NWAIT_W-1:0]    nwait;      // idle cycles between requests
  logic                        run_done;   // one-cycle pulse

  modport regs (
    output enable, rearm, base_line, stride, nlines, nwait,
    input  run_done
  );

  modport addr (
    input enable, base_line, stride
  );

  modport timer (
    input nlines, nwait
  );

  modport fsm (
    output run_done
  );

endinterface : hwpf_cfg_if

// File: design/hwpf_config_regs.sv
/*
 * Stride prefetcher configuration registers
 * Holds the base, param and throttle words with readback. At the end of
 * a run the base line moves on by nlines*stride (rearm) or the enable
 * bit is cleared. A software write in the same cycle takes priority.
 */
`include "hwpf_config.svh"

module hwpf_config_regs
  import hwpf_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    base_set_i,
  input  logic [`HWPF_WORD_W-1:0] base_i,
  output logic [`HWPF_WORD_W-1:0] base_o,
  input  logic                    param_set_i,
  input  logic [`HWPF_WORD_W-1:0] param_i,
  output logic [`HWPF_WORD_W-1:0] param_o,
  input  logic                    throttle_set_i,
  input  logic [`HWPF_WORD_W-1:0] throttle_i,
  output logic [`HWPF_WORD_W-1:0] throttle_o,
  hwpf_cfg_if.regs                cfg
);

  logic [`HWPF_WORD_W-1:0]                  base_q, param_q, throttle_q;
  logic [`HWPF_STRIDE_W+`HWPF_NLINES_W-1:0] run_span;   // lines covered by one run
  line_addr_t                               next_line;

  assign run_span  = param_q[`HWPF_PARAM_NLINES_LSB +: `HWPF_NLINES_W]
                   * param_q[`HWPF_PARAM_STRIDE_LSB +: `HWPF_STRIDE_W];
  assign next_line = base_q[`HWPF_ADDR_W-1:`HWPF_LINE_OFS] + line_addr_t'(run_span);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      param_q    <= '0;
      throttle_q <= '0;
    end else begin
      if (base_set_i) begin
        base_q <= base_i;                 // write wins over run end
      end else if (cfg.run_done) begin
        if (base_q[`HWPF_BASE_REARM_BIT]) begin
          base_q[`HWPF_ADDR_W-1:`HWPF_LINE_OFS] <= next_line;
        end else begin
          base_q[`HWPF_BASE_EN_BIT] <= 1'b0;  // one-shot run, disarm
        end
      end
      if (param_set_i) begin
        param_q <= param_i;
      end
      if (throttle_set_i) begin
        throttle_q <= throttle_i;
      end
    end
  end

  // field decode towards the engine
  assign cfg.enable    = base_q[`HWPF_BASE_EN_BIT];
  assign cfg.rearm     = base_q[`HWPF_BASE_REARM_BIT];
  assign cfg.base_line = base_q[`HWPF_ADDR_W-1:`HWPF_LINE_OFS];
  assign cfg.stride    = param_q[`HWPF_PARAM_STRIDE_LSB +: `HWPF_STRIDE_W];
  assign cfg.nlines    = param_q[`HWPF_PARAM_NLINES_LSB +: `HWPF_NLINES_W];
  assign cfg.nwait     = throttle_q[`HWPF_THROTTLE_NWAIT_LSB +: `HWPF_NWAIT_W];

  assign base_o     = base_q;
  assign param_o    = param_q;
  assign throttle_o = throttle_q;

endmodule : hwpf_config_regs

// File: design/hwpf_addr_gen.sv
/*
 * Stride prefetcher address generator
 * Matches snooped request lines against the armed base line and keeps
 * the line address of the current prefetch request.
 */
`include "hwpf_config.svh"

module hwpf_addr_gen
  import hwpf_pkg::*;
(
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [`HWPF_SNOOP_PORTS-1:0]                  snoop_valid_i,
  input  logic [`HWPF_SNOOP_PORTS-1:0][`HWPF_ADDR_W-1:0] snoop_addr_i,
  hwpf_cfg_if.addr                                      cfg,
  input  logic                                          start_i,
  input  logic                                          step_i,
  output logic                                          trigger_o,
  output logic [`HWPF_ADDR_W-1:0]                       pf_addr_o
);

  line_addr_t cur_line_q;
  line_addr_t stride_ext;
  logic       hit;

  // any snoop port hitting the base line
  always_comb begin
    hit = 1'b0;
    for (int p = 0; p < `HWPF_SNOOP_PORTS; p++) begin
      if (snoop_valid_i[p] &&
          snoop_addr_i[p][`HWPF_ADDR_W-1:`HWPF_LINE_OFS] == cfg.base_line) begin
        hit = 1'b1;
      end
    end
  end

  assign trigger_o  = hit & cfg.enable;  // idle gating is done in the FSM
  assign stride_ext = line_addr_t'(cfg.stride);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_line_q <= '0;
    end else if (start_i) begin
      cur_line_q <= cfg.base_line + stride_ext;  // first line of the run
    end else if (step_i) begin
      cur_line_q <= cur_line_q + stride_ext;
    end
  end

  assign pf_addr_o = {cur_line_q, {`HWPF_LINE_OFS{1'b0}}};

endmodule : hwpf_addr_gen

// File: design/hwpf_throttle_timer.sv
/*
 * Stride prefetcher throttle timer
 * Counts the lines left in a run and the idle cycles spent between two
 * consecutive prefetch requests.
 */
`include "hwpf_config.svh"

module hwpf_throttle_timer (
  input  logic       clk_i,
  input  logic       rst_ni,
  hwpf_cfg_if.timer  cfg,
  input  logic       start_i,
  input  logic       line_issued_i,
  input  logic       wait_start_i,
  output logic       last_o,
  output logic       wait_done_o
);

  logic [`HWPF_NLINES_W-1:0] lines_left_q;
  logic [`HWPF_NWAIT_W-1:0]  wait_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lines_left_q <= '0;
      wait_cnt_q   <= '0;
    end else begin
      if (start_i) begin
        lines_left_q <= cfg.nlines;
      end else if (line_issued_i && lines_left_q != '0) begin
        lines_left_q <= lines_left_q - 1'b1;
      end

      // counts up to nwait and holds there
      if (start_i || wait_start_i) begin
        wait_cnt_q <= '0;
      end else if (!wait_done_o) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  assign last_o      = (lines_left_q == '0);
  assign wait_done_o = (wait_cnt_q == cfg.nwait);  // next request goes up on this edge

endmodule : hwpf_throttle_timer

// File: design/hwpf_issue_fsm.sv
/*
 * Stride prefetcher issue FSM
 * Sequences one prefetch run and drives the four-phase req/ack
 * handshake towards memory, with throttling between requests.
 */
module hwpf_issue_fsm
  import hwpf_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     trigger_i,
  input  logic     last_i,
  input  logic     wait_done_i,
  input  logic     pf_ack_i,
  output logic     start_o,
  output logic     step_o,
  output logic     line_issued_o,
  output logic     wait_start_o,
  output logic     pf_req_o,
  output logic     busy_o,
  hwpf_cfg_if.fsm  cfg
);

  issue_state_e state_q, state_d;
  logic         req_q, req_d;
  logic         busy_q, busy_d;

  always_comb begin
    state_d       = state_q;
    req_d         = req_q;
    busy_d        = busy_q;
    start_o       = 1'b0;
    step_o        = 1'b0;
    line_issued_o = 1'b0;
    wait_start_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (trigger_i) begin
          start_o = 1'b1;
          busy_d  = 1'b1;
          state_d = REQ;
        end
      end
      REQ: begin
        if (!req_q) begin
          if (last_i) begin
            state_d = DONE;     // nlines of zero, nothing to issue
          end else if (!pf_ack_i) begin
            req_d = 1'b1;
          end
        end else if (pf_ack_i) begin
          req_d         = 1'b0;
          line_issued_o = 1'b1;
          state_d       = ACK_LOW;
        end
      end
      ACK_LOW: begin
        if (!pf_ack_i) begin
          if (last_i) begin
            state_d = DONE;
          end else begin
            wait_start_o = 1'b1;
            state_d      = THROTTLE;
          end
        end
      end
      THROTTLE: begin
        // raise the next request directly to keep nwait+1 spacing
        if (wait_done_i) begin
          step_o  = 1'b1;
          req_d   = 1'b1;
          state_d = REQ;
        end
      end
      DONE: begin
        busy_d  = 1'b0;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
      busy_q  <= busy_d;
    end
  end

  assign pf_req_o     = req_q;
  assign busy_o       = busy_q;
  assign cfg.run_done = (state_q == DONE);

endmodule : hwpf_issue_fsm

// File: design/hwpf_stride_top.sv
/*
 * Stride hardware prefetcher
 * Snoops accepted load/store addresses and, once the armed base line is
 * hit, issues a throttled run of line prefetches to memory over a
 * four-phase req/ack handshake.
 */
`include "hwpf_config.svh"

module hwpf_stride_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,

  // snoop of accepted requests
  input  logic [`HWPF_SNOOP_PORTS-1:0]                  snoop_valid_i,
  input  logic [`HWPF_SNOOP_PORTS-1:0][`HWPF_ADDR_W-1:0] snoop_addr_i,

  // configuration words
  input  logic                                          base_set_i,
  input  logic [`HWPF_WORD_W-1:0]                       base_i,
  output logic [`HWPF_WORD_W-1:0]                       base_o,
  input  logic                                          param_set_i,
  input  logic [`HWPF_WORD_W-1:0]                       param_i,
  output logic [`HWPF_WORD_W-1:0]                       param_o,
  input  logic                                          throttle_set_i,
  input  logic [`HWPF_WORD_W-1:0]                       throttle_i,
  output logic [`HWPF_WORD_W-1:0]                       throttle_o,
  output logic                                          busy_o,

  // prefetch requests to memory
  output logic                                          pf_req_o,
  input  logic                                          pf_ack_i,
  output logic [`HWPF_ADDR_W-1:0]                       pf_addr_o
);

  logic trigger;
  logic start, step;
  logic line_issued, wait_start;
  logic last, wait_done;

  hwpf_cfg_if cfg_if ();

  hwpf_config_regs i_hwpf_config_regs (
    .clk_i,
    .rst_ni,
    .base_set_i,
    .base_i,
    .base_o,
    .param_set_i,
    .param_i,
    .param_o,
    .throttle_set_i,
    .throttle_i,
    .throttle_o,
    .cfg            (cfg_if.regs)
  );

  hwpf_addr_gen i_hwpf_addr_gen (
    .clk_i,
    .rst_ni,
    .snoop_valid_i,
    .snoop_addr_i,
    .cfg            (cfg_if.addr),
    .start_i        (start),
    .step_i         (step),
    .trigger_o      (trigger),
    .pf_addr_o
  );

  hwpf_throttle_timer i_hwpf_throttle_timer (
    .clk_i,
    .rst_ni,
    .cfg            (cfg_if.timer),
    .start_i        (start),
    .line_issued_i  (line_issued),
    .wait_start_i   (wait_start),
    .last_o         (last),
    .wait_done_o    (wait_done)
  );

  hwpf_issue_fsm i_hwpf_issue_fsm (
    .clk_i,
    .rst_ni,
    .trigger_i      (trigger),
    .last_i         (last),
    .wait_done_i    (wait_done),
    .pf_ack_i,
    .start_o        (start),
    .step_o         (step),
    .line_issued_o  (line_issued),
    .wait_start_o   (wait_start),
    .pf_req_o,
    .busy_o,
    .cfg            (cfg_if.fsm)
  );

endmodule : hwpf_stride_top

// File: testbench/hwpf_stride_assertions.sv
/*
 * Handshake and busy rules of the prefetch issue FSM
 * Bound into the FSM, checks the four-phase request protocol.
 */
module hwpf_stride_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic pf_req_o,
  input logic pf_ack_i,
  input logic busy_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // request held until the memory side answers
  req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pf_req_o && !pf_ack_i |=> pf_req_o)
    else $error("prefetch request dropped before its acknowledge");

  no_req_rise_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pf_req_o && pf_ack_i |=> !pf_req_o)
    else $error("prefetch request raised while acknowledge still high");

  req_implies_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pf_req_o |-> busy_o)
    else $error("prefetch request high while the engine is not busy");

endmodule : hwpf_stride_assertions

// File: testbench/tb_hwpf_stride.sv
/*
 * Testbench for the stride hardware prefetcher
 * Programs the config words, snoops base lines on both ports and answers
 * prefetch requests with random ack delays. Request addresses, run
 * length, base update and request spacing are checked against a
 * reference model of the prefetch rules.
 */
`include "hwpf_config.svh"

module tb_hwpf_stride;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NL_MAX      = 8;   // largest random nlines
  localparam int NW_MAX      = 5;   // largest random nwait
  localparam int MAX_ACK_DLY = 3;
  localparam int N_RAND      = 6;
  localparam int RUN_CYC     = NL_MAX * (2 * MAX_ACK_DLY + NW_MAX + 4) + 16;
  localparam int TIMEOUT_CYC = (N_RAND + 5) * RUN_CYC + 200;

  logic                                           clk_i = 1'b0;
  logic                                           rst_ni;
  logic [`HWPF_SNOOP_PORTS-1:0]                   snoop_valid_i;
  logic [`HWPF_SNOOP_PORTS-1:0][`HWPF_ADDR_W-1:0] snoop_addr_i;
  logic                                           base_set_i, param_set_i, throttle_set_i;
  logic [`HWPF_WORD_W-1:0]                        base_i, param_i, throttle_i;
  logic [`HWPF_WORD_W-1:0]                        base_o, param_o, throttle_o;
  logic                                           busy_o, pf_req_o, pf_ack_i;
  logic [`HWPF_ADDR_W-1:0]                        pf_addr_o;

  int seed         = 32'h2d1f0afa;
  int cyc          = 0;
  int err_count    = 0;
  int check_count  = 0;
  int req_count    = 0;   // all requests seen so far
  int run_first    = 0;   // req_count when the current run started
  int ack_fall_cyc = 0;
  logic [`HWPF_LINE_W-1:0]   exp_base_line;
  logic [`HWPF_STRIDE_W-1:0] exp_stride;
  logic [`HWPF_NLINES_W-1:0] exp_nlines;
  logic [`HWPF_NWAIT_W-1:0]  exp_nwait;

  hwpf_stride_top i_hwpf_stride_top (.*);

  bind hwpf_issue_fsm hwpf_stride_assertions i_fsm_assertions (
    .clk_i, .rst_ni, .pf_req_o, .pf_ack_i, .busy_o
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic logic [`HWPF_LINE_W-1:0] rand_line();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`HWPF_LINE_W-1:0];
  endfunction

  // line k of a run is base plus k strides
  function automatic logic [`HWPF_LINE_W-1:0] ref_line(input logic [`HWPF_LINE_W-1:0] base,
                                                       input logic [15:0] stride,
                                                       input logic [15:0] k);
    logic [`HWPF_LINE_W-1:0] acc;
    acc = base;
    for (int i = 0; i < k; i++) begin
      acc = acc + {{(`HWPF_LINE_W-16){1'b0}}, stride};
    end
    return acc;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic write_config(input logic [`HWPF_LINE_W-1:0] line, input logic en,
                              input logic rearm, input logic [15:0] stride,
                              input logic [15:0] nlines, input logic [15:0] nwait);
    base_i         = {line, 4'b0000, rearm, en};
    param_i        = {32'h5a5a_c3c3, nlines, stride};   // upper bits only read back
    throttle_i     = {48'h0000_1357_9bdf, nwait};
    base_set_i     = 1'b1;
    param_set_i    = 1'b1;
    throttle_set_i = 1'b1;
    @(negedge clk_i);
    base_set_i     = 1'b0;
    param_set_i    = 1'b0;
    throttle_set_i = 1'b0;
    check_value("base_o", base_o, base_i);
    check_value("param_o", param_o, param_i);
    check_value("throttle_o", throttle_o, throttle_i);
  endtask

  task automatic start_run(input int port, input logic [`HWPF_LINE_W-1:0] line,
                           input logic [15:0] stride, input logic [15:0] nlines,
                           input logic [15:0] nwait, input logic rearm);
    logic [`HWPF_WORD_W-1:0] exp_base;
    exp_base_line       = line;
    exp_stride          = stride;
    exp_nlines          = nlines;
    exp_nwait           = nwait;
    run_first           = req_count;
    snoop_addr_i[port]  = {line, 6'(rand_range(0, 63))};
    snoop_valid_i[port] = 1'b1;
    @(negedge clk_i);
    snoop_valid_i = '0;
    check_value("busy_o", busy_o, 1'b1);
    snoop_addr_i  = {2{line, 6'h00}};   // base line hit on every busy cycle, ignored
    snoop_valid_i = '1;
    @(negedge clk_i);
    check_value("pf_req_o", pf_req_o, nlines != 0);
    while (busy_o) @(negedge clk_i);
    snoop_valid_i = '0;
    check_value("request count", req_count - run_first, nlines);
    if (rearm) begin
      exp_base = {ref_line(line, stride, nlines), 4'b0000, 2'b11};
    end else begin
      exp_base = {line, 6'b000000};   // enable dropped
    end
    check_value("base_o", base_o, exp_base);
    repeat (3) @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
  endtask

  task automatic expect_no_run(input int port, input logic [`HWPF_LINE_W-1:0] line);
    exp_nlines          = '0;   // any request now is unexpected
    run_first           = req_count;
    snoop_addr_i[port]  = {line, 6'h3f};
    snoop_valid_i[port] = 1'b1;
    @(negedge clk_i);
    snoop_valid_i = '0;
    repeat (4) begin
      check_value("busy_o", busy_o, 1'b0);
      @(negedge clk_i);
    end
  endtask

  // memory side, four-phase handshake with random delays
  initial begin : responder
    int dly;
    pf_ack_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (pf_req_o && !pf_ack_i) begin
        dly = rand_range(0, MAX_ACK_DLY);
        repeat (dly) @(negedge clk_i);
        pf_ack_i = 1'b1;
        @(negedge clk_i);
        while (pf_req_o) @(negedge clk_i);
        dly = rand_range(0, MAX_ACK_DLY);
        repeat (dly) @(negedge clk_i);
        pf_ack_i     = 1'b0;
        ack_fall_cyc = cyc;   // DUT samples it low on the next edge
      end
    end
  end

  initial begin : compare
    logic              req_prev;
    logic [63:0]       exp_addr;
    int                k;
    req_prev = 1'b0;
    forever begin
      @(negedge clk_i);
      if (pf_req_o && !req_prev) begin
        req_count++;
        k = req_count - run_first;
        if (k > exp_nlines) begin
          err_count++;
          $display("Unexpected prefetch request at %0t to address 0x%0h", $time, pf_addr_o);
        end else begin
          exp_addr = {ref_line(exp_base_line, exp_stride, 16'(k)), {`HWPF_LINE_OFS{1'b0}}};
          check_value("pf_addr_o", pf_addr_o, exp_addr);
          if (k > 1) begin
            check_value("pf_req_o rise cycle", cyc, ack_fall_cyc + exp_nwait + 2);
          end
        end
      end
      req_prev = pf_req_o;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYC);
    $display("Finished with errors");
    $finish;
  end

  initial begin : stimulus
    logic [`HWPF_LINE_W-1:0] line;
    logic [15:0]             stride, nlines, nwait;
    logic                    rearm;
    int                      port;
    rst_ni         = 1'b0;
    snoop_valid_i  = '0;
    snoop_addr_i   = '0;
    base_set_i     = 1'b0;
    param_set_i    = 1'b0;
    throttle_set_i = 1'b0;
    base_i         = '0;
    param_i        = '0;
    throttle_i     = '0;
    exp_base_line  = '0;
    exp_stride     = '0;
    exp_nlines     = '0;
    exp_nwait      = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("pf_req_o", pf_req_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("base_o", base_o, '0);
    check_value("param_o", param_o, '0);
    check_value("throttle_o", throttle_o, '0);

    // one-shot run, then the same line with enable clear
    line = 58'h0_00ab_cdef_0120;
    write_config(line, 1'b1, 1'b0, 16'd3, 16'd4, 16'd2);
    start_run(0, line, 16'd3, 16'd4, 16'd2, 1'b0);
    expect_no_run(1, line);
    write_config(line, 1'b1, 1'b0, 16'd3, 16'd4, 16'd2);
    expect_no_run(0, line + 1);

    // rearm mode, second run starts from the advanced base
    line = 58'h3_ff00_0000_1000;
    write_config(line, 1'b1, 1'b1, 16'd5, 16'd3, 16'd0);
    start_run(1, line, 16'd5, 16'd3, 16'd0, 1'b1);
    start_run(0, ref_line(line, 16'd5, 16'd3), 16'd5, 16'd3, 16'd0, 1'b1);

    write_config(line, 1'b1, 1'b0, 16'd7, 16'd0, 16'd1);   // empty run
    start_run(1, line, 16'd7, 16'd0, 16'd1, 1'b0);

    repeat (N_RAND) begin
      line   = rand_line();
      stride = 16'(rand_range(1, 300));
      nlines = 16'(rand_range(1, NL_MAX));
      nwait  = 16'(rand_range(0, NW_MAX));
      rearm  = 1'(rand_range(0, 1));
      port   = rand_range(0, 1);
      write_config(line, 1'b1, rearm, stride, nlines, nwait);
      start_run(port, line, stride, nlines, nwait, rearm);
    end

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_hwpf_stride

// File: hwpf_stride.f
+incdir+design
design/hwpf_pkg.sv
design/hwpf_cfg_if.sv
design/hwpf_config_regs.sv
design/hwpf_addr_gen.sv
design/hwpf_throttle_timer.sv
design/hwpf_issue_fsm.sv
design/hwpf_stride_top.sv
testbench/hwpf_stride_assertions.sv
testbench/tb_hwpf_stride.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stride prefetcher testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_hwpf_stride -f hwpf_stride.f -o tb_hwpf_stride \
  && ./obj_dir/tb_hwpf_stride > "$LOG" 2>&1
status=$?
cat "$LOG" 2>/dev/null
grep -q "Finished with errors" "$LOG" && { echo "TEST FAILED"; exit 1; }
[ "$status" -eq 0 ] || { echo "TEST FAILED: build or simulation error"; exit 1; }
echo "TEST PASSED"
